//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_int_backend -f list.f -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "FAIL: see errors above" sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
rtl/backend_cfg_pkg.sv
rtl/issue_types_pkg.sv
rtl/issue_bank_if.sv
rtl/issue_bank.sv
rtl/bank_sorter.sv
rtl/int_issue_queue.sv
rtl/int_regfile.sv
rtl/int_alu.sv
rtl/int_backend_top.sv
verif/int_backend_checker.sv
verif/tb_int_backend.sv

//--- rtl/backend_cfg_pkg.sv
`default_nettype none

package backend_cfg_pkg;

    // physical register tag, 64 registers.
    localparam int PREG_WIDTH = 6;

    // integer data path width.
    localparam int XLEN = 32;

    // ordering tag carried through to writeback.
    localparam int ROB_WIDTH = 5;

    // immediate field, sign-extended in the ALU.
    localparam int IMM_WIDTH = 12;

endpackage

`default_nettype wire

//--- rtl/bank_sorter.sv
`default_nettype none

module bank_sorter #(
    parameter int ALU_NUM = 2,
    parameter int BANK_DEPTH = 4
) (
    input  logic                                             clk,
    input  logic                                             rst_n_i,
    input  logic [ALU_NUM-1:0][$clog2(BANK_DEPTH + 1)-1:0]   count_i,
    output logic [ALU_NUM-1:0][$clog2(ALU_NUM)-1:0]          order_o
);
    localparam int IDX_W = $clog2(ALU_NUM);

    logic [ALU_NUM-1:0][IDX_W-1:0] rank;
    logic [ALU_NUM-1:0][IDX_W-1:0] order_d;

    // rank is the number of banks that sort ahead; ties go to the lower index.
    always_comb begin
        order_d = '0;
        for (int b = 0; b < ALU_NUM; b++) begin
            rank[b] = '0;
            for (int c = 0; c < ALU_NUM; c++) begin
                if (count_i[c] < count_i[b] || (count_i[c] == count_i[b] && c < b)) begin
                    rank[b] = rank[b] + 1'b1;
                end
            end
        end
        for (int b = 0; b < ALU_NUM; b++) begin
            order_d[rank[b]] = IDX_W'(b);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int k = 0; k < ALU_NUM; k++) begin
                order_o[k] <= IDX_W'(k);
            end
        end else begin
            order_o <= order_d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
`default_nettype none

module int_alu (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  logic                                    en_i,
    input  logic [backend_cfg_pkg::XLEN-1:0]        rs1_data_i,
    input  logic [backend_cfg_pkg::XLEN-1:0]        rs2_data_i,
    input  issue_types_pkg::issue_bundle_t          bundle_i,
    output logic                                    wb_en_o,
    output logic [backend_cfg_pkg::PREG_WIDTH-1:0]  wb_rd_o,
    output logic [backend_cfg_pkg::XLEN-1:0]        wb_data_o,
    output logic [backend_cfg_pkg::ROB_WIDTH-1:0]   wb_rob_o
);
    localparam int XLEN = backend_cfg_pkg::XLEN;
    localparam int IMM_W = backend_cfg_pkg::IMM_WIDTH;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;

    assign op_b = bundle_i.use_imm ?
                  {{(XLEN - IMM_W){bundle_i.imm[IMM_W-1]}}, bundle_i.imm} : rs2_data_i;

    always_comb begin
        result = '0;
        case (bundle_i.op)
            issue_types_pkg::ALU_ADD: result = rs1_data_i + op_b;
            issue_types_pkg::ALU_SUB: result = rs1_data_i - op_b;
            issue_types_pkg::ALU_AND: result = rs1_data_i & op_b;
            issue_types_pkg::ALU_OR:  result = rs1_data_i | op_b;
            issue_types_pkg::ALU_XOR: result = rs1_data_i ^ op_b;
            issue_types_pkg::ALU_SLL: result = rs1_data_i << op_b[4:0];
            issue_types_pkg::ALU_SRL: result = rs1_data_i >> op_b[4:0];
            issue_types_pkg::ALU_SLT: begin
                result = {{(XLEN - 1){1'b0}}, $signed(rs1_data_i) < $signed(op_b)};
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o <= en_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= bundle_i.rd;
        wb_data_o <= result;
        wb_rob_o  <= bundle_i.rob_idx;
    end

endmodule

`default_nettype wire

//--- rtl/int_backend_top.sv
`default_nettype none

module int_backend_top #(
    parameter int ALU_NUM = 2,
    parameter int BANK_DEPTH = 4,
    parameter int DISPATCH_WIDTH = ALU_NUM
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n_i,
    input  logic [DISPATCH_WIDTH-1:0]                            dis_en_i,
    input  issue_types_pkg::issue_status_t [DISPATCH_WIDTH-1:0]  dis_status_i,
    input  issue_types_pkg::issue_bundle_t [DISPATCH_WIDTH-1:0]  dis_bundle_i,
    output logic                                                 dis_full_o,
    output logic [ALU_NUM-1:0]                                   wb_en_o,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0]  wb_rd_o,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]        wb_data_o,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::ROB_WIDTH-1:0]   wb_rob_o
);
    logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0] rf_rs1;
    logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0] rf_rs2;
    logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]       rf_rs1_data;
    logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]       rf_rs2_data;
    logic [ALU_NUM-1:0]                                  alu_en;
    logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]       alu_rs1_data;
    logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]       alu_rs2_data;
    issue_types_pkg::issue_bundle_t [ALU_NUM-1:0]        alu_bundle;

    int_issue_queue #(
        .ALU_NUM       (ALU_NUM),
        .BANK_DEPTH    (BANK_DEPTH),
        .DISPATCH_WIDTH(DISPATCH_WIDTH)
    ) u_queue (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .dis_en_i      (dis_en_i),
        .dis_status_i  (dis_status_i),
        .dis_bundle_i  (dis_bundle_i),
        .dis_full_o    (dis_full_o),
        .wb_en_i       (wb_en_o),
        .wb_rd_i       (wb_rd_o),
        .rf_rs1_o      (rf_rs1),
        .rf_rs2_o      (rf_rs2),
        .rf_rs1_data_i (rf_rs1_data),
        .rf_rs2_data_i (rf_rs2_data),
        .alu_en_o      (alu_en),
        .alu_rs1_data_o(alu_rs1_data),
        .alu_rs2_data_o(alu_rs2_data),
        .alu_bundle_o  (alu_bundle)
    );

    int_regfile #(
        .ALU_NUM(ALU_NUM)
    ) u_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .rs1_i     (rf_rs1),
        .rs2_i     (rf_rs2),
        .wb_en_i   (wb_en_o),
        .wb_rd_i   (wb_rd_o),
        .wb_data_i (wb_data_o),
        .rs1_data_o(rf_rs1_data),
        .rs2_data_o(rf_rs2_data)
    );

    for (genvar a = 0; a < ALU_NUM; a++) begin : g_alu
        int_alu u_alu (
            .clk       (clk),
            .rst_n_i   (rst_n_i),
            .en_i      (alu_en[a]),
            .rs1_data_i(alu_rs1_data[a]),
            .rs2_data_i(alu_rs2_data[a]),
            .bundle_i  (alu_bundle[a]),
            .wb_en_o   (wb_en_o[a]),
            .wb_rd_o   (wb_rd_o[a]),
            .wb_data_o (wb_data_o[a]),
            .wb_rob_o  (wb_rob_o[a])
        );
    end

endmodule

`default_nettype wire

//--- rtl/int_issue_queue.sv
`default_nettype none

module int_issue_queue #(
    parameter int ALU_NUM = 2,
    parameter int BANK_DEPTH = 4,
    parameter int DISPATCH_WIDTH = 2
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n_i,
    input  logic [DISPATCH_WIDTH-1:0]                             dis_en_i,
    input  issue_types_pkg::issue_status_t [DISPATCH_WIDTH-1:0]   dis_status_i,
    input  issue_types_pkg::issue_bundle_t [DISPATCH_WIDTH-1:0]   dis_bundle_i,
    output logic                                                  dis_full_o,
    input  logic [ALU_NUM-1:0]                                    wb_en_i,
    input  logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0]   wb_rd_i,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0]   rf_rs1_o,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0]   rf_rs2_o,
    input  logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]         rf_rs1_data_i,
    input  logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]         rf_rs2_data_i,
    output logic [ALU_NUM-1:0]                                    alu_en_o,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]         alu_rs1_data_o,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]         alu_rs2_data_o,
    output issue_types_pkg::issue_bundle_t [ALU_NUM-1:0]          alu_bundle_o
);
    localparam int CNT_W = $clog2(BANK_DEPTH + 1);
    localparam int IDX_W = $clog2(ALU_NUM);

    issue_bank_if #(.BANK_DEPTH(BANK_DEPTH), .ALU_NUM(ALU_NUM)) bank_if [ALU_NUM] ();

    logic [ALU_NUM-1:0]                     bank_en;
    logic [ALU_NUM-1:0]                     bank_full;
    logic [ALU_NUM-1:0]                     issue_en;
    logic [ALU_NUM-1:0][CNT_W-1:0]          bank_count;
    logic [ALU_NUM-1:0][IDX_W-1:0]          order;
    issue_types_pkg::issue_status_t [ALU_NUM-1:0] bank_status;
    issue_types_pkg::issue_bundle_t [ALU_NUM-1:0] bank_bundle;
    issue_types_pkg::issue_bundle_t [ALU_NUM-1:0] issue_bundle;

    for (genvar b = 0; b < ALU_NUM; b++) begin : g_bank
        issue_bank #(
            .BANK_DEPTH(BANK_DEPTH),
            .ALU_NUM   (ALU_NUM)
        ) u_bank (
            .clk    (clk),
            .rst_n_i(rst_n_i),
            .io     (bank_if[b])
        );

        assign bank_if[b].en     = bank_en[b];
        assign bank_if[b].status = bank_status[b];
        assign bank_if[b].bundle = bank_bundle[b];
        assign bank_if[b].wb_en  = wb_en_i;
        assign bank_if[b].wb_tag = wb_rd_i;
        assign bank_full[b]      = bank_if[b].full;
        assign bank_count[b]     = bank_if[b].count;
        assign issue_en[b]       = bank_if[b].issue_en;
        assign issue_bundle[b]   = bank_if[b].bundle_o;
        assign rf_rs1_o[b]       = bank_if[b].rs1;
        assign rf_rs2_o[b]       = bank_if[b].rs2;
    end

    bank_sorter #(
        .ALU_NUM   (ALU_NUM),
        .BANK_DEPTH(BANK_DEPTH)
    ) u_sorter (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .count_i(bank_count),
        .order_o(order)
    );

    // stall every slot if any enabled slot lands on a full bank.
    always_comb begin
        dis_full_o = 1'b0;
        for (int k = 0; k < DISPATCH_WIDTH; k++) begin
            if (dis_en_i[k] && bank_full[order[k]]) dis_full_o = 1'b1;
        end
    end

    // slot k goes to bank order[k].
    always_comb begin
        bank_en     = '0;
        bank_status = '0;
        bank_bundle = '0;
        for (int b = 0; b < ALU_NUM; b++) begin
            for (int k = 0; k < DISPATCH_WIDTH; k++) begin
                if (order[k] == IDX_W'(b)) begin
                    bank_en[b]     = dis_en_i[k] & ~dis_full_o;
                    bank_status[b] = dis_status_i[k];
                    bank_bundle[b] = dis_bundle_i[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_en_o <= '0;
        end else begin
            alu_en_o <= issue_en;
        end
    end

    always_ff @(posedge clk) begin
        alu_rs1_data_o <= rf_rs1_data_i;
        alu_rs2_data_o <= rf_rs2_data_i;
        alu_bundle_o   <= issue_bundle;
    end

endmodule

`default_nettype wire

//--- rtl/int_regfile.sv
`default_nettype none

module int_regfile #(
    parameter int ALU_NUM = 2
) (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    input  logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0] rs1_i,
    input  logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0] rs2_i,
    input  logic [ALU_NUM-1:0]                                  wb_en_i,
    input  logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0] wb_rd_i,
    input  logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]       wb_data_i,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]       rs1_data_o,
    output logic [ALU_NUM-1:0][backend_cfg_pkg::XLEN-1:0]       rs2_data_o
);
    localparam int NUM_REGS = 2 ** backend_cfg_pkg::PREG_WIDTH;

    logic [backend_cfg_pkg::XLEN-1:0] regs [NUM_REGS];

    // later ports overwrite earlier ones on a shared tag.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int a = 0; a < ALU_NUM; a++) begin
                if (wb_en_i[a]) regs[wb_rd_i[a]] <= wb_data_i[a];
            end
        end
    end

    always_comb begin
        for (int a = 0; a < ALU_NUM; a++) begin
            rs1_data_o[a] = regs[rs1_i[a]];
            rs2_data_o[a] = regs[rs2_i[a]];
        end
    end

endmodule

`default_nettype wire

//--- rtl/issue_bank.sv
`default_nettype none

module issue_bank #(
    parameter int BANK_DEPTH = 4,
    parameter int ALU_NUM = 2
) (
    input logic        clk,
    input logic        rst_n_i,
    issue_bank_if.bank io
);
    localparam int IDX_W = $clog2(BANK_DEPTH);

    logic [BANK_DEPTH-1:0]                  valid;
    // older[i][j] is set when entry i arrived before entry j.
    logic [BANK_DEPTH-1:0][BANK_DEPTH-1:0]  older;
    issue_types_pkg::issue_status_t         status_q [BANK_DEPTH];
    issue_types_pkg::issue_bundle_t         bundle_q [BANK_DEPTH];
    logic [BANK_DEPTH-1:0]                  wake1;
    logic [BANK_DEPTH-1:0]                  wake2;
    logic [BANK_DEPTH-1:0]                  ready;
    logic [BANK_DEPTH-1:0]                  grant;
    logic [BANK_DEPTH-1:0]                  free_oh;
    logic [IDX_W-1:0]                       sel_idx;
    logic                                   in_wake1;
    logic                                   in_wake2;

    // tag match against every writeback port, for stored and incoming entries.
    always_comb begin
        in_wake1 = 1'b0;
        in_wake2 = 1'b0;
        for (int a = 0; a < ALU_NUM; a++) begin
            if (io.wb_en[a] && io.wb_tag[a] == io.status.rs1) in_wake1 = 1'b1;
            if (io.wb_en[a] && io.wb_tag[a] == io.status.rs2) in_wake2 = 1'b1;
        end
        for (int i = 0; i < BANK_DEPTH; i++) begin
            wake1[i] = 1'b0;
            wake2[i] = 1'b0;
            for (int a = 0; a < ALU_NUM; a++) begin
                if (io.wb_en[a] && io.wb_tag[a] == status_q[i].rs1) wake1[i] = 1'b1;
                if (io.wb_en[a] && io.wb_tag[a] == status_q[i].rs2) wake2[i] = 1'b1;
            end
            ready[i] = valid[i] & status_q[i].rs1_ready & status_q[i].rs2_ready;
        end
    end

    // an entry wins when no other ready entry is older.
    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            grant[i] = ready[i];
            for (int j = 0; j < BANK_DEPTH; j++) begin
                if (j != i && ready[j] && older[j][i]) grant[i] = 1'b0;
            end
            if (grant[i]) sel_idx = IDX_W'(i);
        end
    end

    // lowest free slot.
    assign free_oh = ~valid & (valid + 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid <= '0;
            older <= '0;
        end else begin
            valid <= (valid & ~grant) | (free_oh & {BANK_DEPTH{io.en}});
            for (int i = 0; i < BANK_DEPTH; i++) begin
                if (io.en && free_oh[i]) begin
                    for (int j = 0; j < BANK_DEPTH; j++) begin
                        older[i][j] <= 1'b0;
                        older[j][i] <= (j != i);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < BANK_DEPTH; i++) begin
            if (io.en && free_oh[i]) begin
                status_q[i]           <= io.status;
                status_q[i].rs1_ready <= io.status.rs1_ready | in_wake1;
                status_q[i].rs2_ready <= io.status.rs2_ready | in_wake2;
                bundle_q[i]           <= io.bundle;
            end else begin
                if (wake1[i]) status_q[i].rs1_ready <= 1'b1;
                if (wake2[i]) status_q[i].rs2_ready <= 1'b1;
            end
        end
    end

    always_comb begin
        io.count = '0;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            io.count = io.count + valid[i];
        end
    end

    assign io.full     = &valid;
    assign io.issue_en = |ready;
    assign io.rs1      = status_q[sel_idx].rs1;
    assign io.rs2      = status_q[sel_idx].rs2;
    assign io.bundle_o = bundle_q[sel_idx];

endmodule

`default_nettype wire

//--- rtl/issue_bank_if.sv
`default_nettype none

interface issue_bank_if #(
    parameter int BANK_DEPTH = 4,
    parameter int ALU_NUM = 2
);
    localparam int CNT_W = $clog2(BANK_DEPTH + 1);

    // dispatch side.
    logic                          en;
    issue_types_pkg::issue_status_t status;
    issue_types_pkg::issue_bundle_t bundle;

    // occupancy and issue read-out.
    logic                                   full;
    logic [CNT_W-1:0]                       count;
    logic                                   issue_en;
    logic [backend_cfg_pkg::PREG_WIDTH-1:0] rs1;
    logic [backend_cfg_pkg::PREG_WIDTH-1:0] rs2;
    issue_types_pkg::issue_bundle_t         bundle_o;

    // wakeup broadcast, one tag per ALU.
    logic [ALU_NUM-1:0]                                  wb_en;
    logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0] wb_tag;

    modport bank (
        input  en, status, bundle, wb_en, wb_tag,
        output full, count, issue_en, rs1, rs2, bundle_o
    );

    modport queue (
        output en, status, bundle, wb_en, wb_tag,
        input  full, count, issue_en, rs1, rs2, bundle_o
    );

endinterface

`default_nettype wire

//--- rtl/issue_types_pkg.sv
`default_nettype none

package issue_types_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // source tags and their ready bits, 14 bits.
    typedef struct packed {
        logic [backend_cfg_pkg::PREG_WIDTH-1:0] rs1;
        logic [backend_cfg_pkg::PREG_WIDTH-1:0] rs2;
        logic                                   rs1_ready;
        logic                                   rs2_ready;
    } issue_status_t;

    // payload handed to the ALU, 27 bits.
    typedef struct packed {
        alu_op_e                                op;
        logic                                   use_imm;
        logic [backend_cfg_pkg::IMM_WIDTH-1:0]  imm;
        logic [backend_cfg_pkg::PREG_WIDTH-1:0] rd;
        logic [backend_cfg_pkg::ROB_WIDTH-1:0]  rob_idx;
    } issue_bundle_t;

endpackage

`default_nettype wire

//--- verif/int_backend_checker.sv
`default_nettype none

module int_backend_checker #(
    parameter int ALU_NUM = 2
) (
    input logic                                                clk,
    input logic                                                rst_n_i,
    input logic                                                dis_full_i,
    input logic [ALU_NUM-1:0]                                  wb_en_i,
    input logic [ALU_NUM-1:0][backend_cfg_pkg::PREG_WIDTH-1:0] wb_rd_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // the ALU outputs are cleared by the reset edge.
    a_no_wb_in_reset: assert property (@(posedge clk) !rst_n_i |=> wb_en_i == '0)
        else $error("writeback enable high while in reset");

    // banks come out of reset empty and take the first dispatch.
    a_not_full_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |=> !dis_full_i)
        else $error("dispatch full right after reset");

    for (genvar i = 0; i < ALU_NUM; i++) begin : g_port_a
        for (genvar j = i + 1; j < ALU_NUM; j++) begin : g_port_b
            a_distinct_rd: assert property (@(posedge clk) disable iff (!rst_n_i)
                wb_en_i[i] && wb_en_i[j] |-> wb_rd_i[i] != wb_rd_i[j])
                else $error("two writebacks to the same tag in one cycle");
        end
    end

endmodule

bind int_backend_top int_backend_checker #(.ALU_NUM(ALU_NUM)) u_checker (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .dis_full_i(dis_full_o),
    .wb_en_i   (wb_en_o),
    .wb_rd_i   (wb_rd_o)
);

`default_nettype wire

//--- verif/tb_int_backend.sv
`default_nettype none

module tb_int_backend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int ALU_NUM = 2;
    localparam int DW = 2;
    localparam int XW = backend_cfg_pkg::XLEN;
    localparam int PW = backend_cfg_pkg::PREG_WIDTH;
    localparam int RW = backend_cfg_pkg::ROB_WIDTH;
    localparam int IW = backend_cfg_pkg::IMM_WIDTH;
    localparam int TIMEOUT = 300;

    logic                                     clk;
    logic                                     rst_n_i;
    logic [DW-1:0]                            dis_en_i;
    issue_types_pkg::issue_status_t [DW-1:0]  dis_status_i;
    issue_types_pkg::issue_bundle_t [DW-1:0]  dis_bundle_i;
    logic                                     dis_full_o;
    logic [ALU_NUM-1:0]                       wb_en_o;
    logic [ALU_NUM-1:0][PW-1:0]               wb_rd_o;
    logic [ALU_NUM-1:0][XW-1:0]               wb_data_o;
    logic [ALU_NUM-1:0][RW-1:0]               wb_rob_o;

    // reference register values and per-rob bookkeeping.
    logic [XW-1:0]                  model_regs [64];
    bit                             preg_written [64];
    bit                             got [32];
    logic [PW-1:0]                  got_rd [32];
    logic [XW-1:0]                  got_data [32];
    int                             got_seq [32];
    issue_types_pkg::issue_status_t op_status [32];
    issue_types_pkg::issue_bundle_t op_bundle [32];
    int                             next_preg;
    int                             next_rob;
    int                             wb_count;
    bit                             saw_full;

    int_backend_top #(
        .ALU_NUM       (ALU_NUM),
        .BANK_DEPTH    (4),
        .DISPATCH_WIDTH(DW)
    ) dut_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dis_en_i    (dis_en_i),
        .dis_status_i(dis_status_i),
        .dis_bundle_i(dis_bundle_i),
        .dis_full_o  (dis_full_o),
        .wb_en_o     (wb_en_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o),
        .wb_rob_o    (wb_rob_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input logic [XW-1:0] actual, input logic [XW-1:0] expected,
                              input string what);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                               $time, what, actual, expected));
        end
    endtask

    task automatic check_tag(input logic [PW-1:0] actual, input logic [PW-1:0] expected,
                             input string what);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED at %0t: %s is p%0d, expected p%0d",
                               $time, what, actual, expected));
        end
    endtask

    task automatic check_before(input int first_rob, input int later_rob);
        if (got_seq[first_rob] >= got_seq[later_rob]) begin
            stop_run($sformatf("FAILED at %0t: rob %0d wrote back before rob %0d",
                               $time, later_rob, first_rob));
        end
    endtask

    // record every writeback while the outputs are stable.
    always @(negedge clk) begin
        if (rst_n_i) begin
            for (int a = 0; a < ALU_NUM; a++) begin
                if (wb_en_o[a]) begin
                    if (got[wb_rob_o[a]]) begin
                        stop_run($sformatf("FAILED at %0t: rob %0d written back twice",
                                           $time, wb_rob_o[a]));
                    end
                    got[wb_rob_o[a]]      = 1'b1;
                    got_rd[wb_rob_o[a]]   = wb_rd_o[a];
                    got_data[wb_rob_o[a]] = wb_data_o[a];
                    got_seq[wb_rob_o[a]]  = wb_count;
                    wb_count++;
                    preg_written[wb_rd_o[a]] = 1'b1;
                end
            end
        end
    end

    function automatic logic [XW-1:0] expected_result(input issue_types_pkg::alu_op_e op,
                                                      input logic [XW-1:0] a,
                                                      input logic [XW-1:0] b);
        case (op)
            issue_types_pkg::ALU_ADD: return a + b;
            issue_types_pkg::ALU_SUB: return a - b;
            issue_types_pkg::ALU_AND: return a & b;
            issue_types_pkg::ALU_OR:  return a | b;
            issue_types_pkg::ALU_XOR: return a ^ b;
            issue_types_pkg::ALU_SLL: return a << b[4:0];
            issue_types_pkg::ALU_SRL: return a >> b[4:0];
            default:                  return ($signed(a) < $signed(b)) ? XW'(1) : XW'(0);
        endcase
    endfunction

    task automatic prepare_op(input issue_types_pkg::alu_op_e op, input int rs1, input int rs2,
                              input bit use_imm, input logic [IW-1:0] imm, output int rob);
        rob = next_rob;
        next_rob = (next_rob + 1) % 32;
        got[rob] = 1'b0;
        op_status[rob] = '0;
        op_status[rob].rs1 = PW'(rs1);
        op_status[rob].rs2 = use_imm ? '0 : PW'(rs2);
        op_bundle[rob].op = op;
        op_bundle[rob].use_imm = use_imm;
        op_bundle[rob].imm = imm;
        op_bundle[rob].rd = PW'(next_preg);
        op_bundle[rob].rob_idx = RW'(rob);
        next_preg++;
    endtask

    // ready bits follow the writebacks seen so far.
    task automatic drive_slot(input int k, input int rob);
        dis_status_i[k] = op_status[rob];
        dis_status_i[k].rs1_ready = preg_written[op_status[rob].rs1];
        dis_status_i[k].rs2_ready = preg_written[op_status[rob].rs2];
        dis_bundle_i[k] = op_bundle[rob];
    endtask

    task automatic dispatch_ops(input int rob0, input int rob1, input bit two);
        int waited;
        waited = 0;
        @(negedge clk);
        dis_en_i = {two, 1'b1};
        drive_slot(0, rob0);
        drive_slot(1, two ? rob1 : rob0);
        #1;
        while (dis_full_o) begin
            saw_full = 1'b1;
            waited++;
            if (waited > TIMEOUT) stop_run("timeout: dispatch stayed blocked by dis_full_o");
            @(negedge clk);
            drive_slot(0, rob0);
            drive_slot(1, two ? rob1 : rob0);
            #1;
        end
        @(negedge clk);
        dis_en_i = '0;
    endtask

    task automatic check_op(input int rob);
        int waited;
        logic [XW-1:0] a;
        logic [XW-1:0] b;
        waited = 0;
        while (!got[rob]) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) stop_run($sformatf("timeout: no writeback for rob %0d", rob));
        end
        a = model_regs[op_status[rob].rs1];
        b = op_bundle[rob].use_imm ? {{(XW - IW){op_bundle[rob].imm[IW-1]}}, op_bundle[rob].imm}
                                   : model_regs[op_status[rob].rs2];
        check_tag(got_rd[rob], op_bundle[rob].rd, $sformatf("rob %0d rd", rob));
        check_data(got_data[rob], expected_result(op_bundle[rob].op, a, b),
                   $sformatf("rob %0d result", rob));
        model_regs[got_rd[rob]] = got_data[rob];
    endtask

    task automatic run_single(input issue_types_pkg::alu_op_e op, input int rs1,
                              input logic [IW-1:0] imm, output int rd);
        int rob;
        prepare_op(op, rs1, 0, 1'b1, imm, rob);
        dispatch_ops(rob, rob, 1'b0);
        check_op(rob);
        rd = op_bundle[rob].rd;
    endtask

    task automatic build_random(output int rd);
        int r;
        run_single(issue_types_pkg::ALU_ADD, 0, IW'($urandom), r);
        run_single(issue_types_pkg::ALU_SLL, r, 12'd20, r);
        run_single(issue_types_pkg::ALU_XOR, r, IW'($urandom), rd);
    endtask

    task automatic test_independent_imm();
        int r0;
        int r1;
        prepare_op(issue_types_pkg::ALU_ADD, 0, 0, 1'b1, 12'h123, r0);
        prepare_op(issue_types_pkg::ALU_ADD, 0, 0, 1'b1, 12'hf80, r1);
        dispatch_ops(r0, r1, 1'b1);
        check_op(r0);
        check_op(r1);
    endtask

    task automatic test_every_opcode();
        int x;
        int y;
        int robs [8];
        build_random(x);
        build_random(y);
        for (int k = 0; k < 8; k += 2) begin
            prepare_op(issue_types_pkg::alu_op_e'(k), x, y, 1'b0, '0, robs[k]);
            prepare_op(issue_types_pkg::alu_op_e'(k + 1), y, x, 1'b0, '0, robs[k + 1]);
            dispatch_ops(robs[k], robs[k + 1], 1'b1);
        end
        for (int k = 0; k < 8; k++) check_op(robs[k]);
    endtask

    task automatic test_dependency_chain();
        int robs [4];
        prepare_op(issue_types_pkg::ALU_ADD, 0, 0, 1'b1, 12'h0a5, robs[0]);
        dispatch_ops(robs[0], robs[0], 1'b0);
        for (int k = 1; k < 4; k++) begin
            prepare_op(k[0] ? issue_types_pkg::ALU_SUB : issue_types_pkg::ALU_XOR,
                       op_bundle[robs[k - 1]].rd, 0, 1'b1, IW'(k * 37), robs[k]);
            dispatch_ops(robs[k], robs[k], 1'b0);
        end
        check_op(robs[0]);
        for (int k = 1; k < 4; k++) begin
            check_op(robs[k]);
            check_before(robs[k - 1], robs[k]);
        end
    endtask

    task automatic test_out_of_order();
        int p;
        int w;
        int f;
        int i;
        prepare_op(issue_types_pkg::ALU_ADD, 0, 0, 1'b1, 12'h3c3, p);
        prepare_op(issue_types_pkg::ALU_ADD, op_bundle[p].rd, 0, 1'b1, 12'h011, w);
        prepare_op(issue_types_pkg::ALU_XOR, op_bundle[p].rd, 0, 1'b1, 12'h0f0, f);
        prepare_op(issue_types_pkg::ALU_ADD, 0, 0, 1'b1, 12'h055, i);
        // equal counts send the lone slot to the bank that holds w.
        dispatch_ops(w, f, 1'b1);
        dispatch_ops(i, i, 1'b0);
        dispatch_ops(p, p, 1'b0);
        check_op(i);
        check_op(p);
        check_op(w);
        check_op(f);
        check_before(i, w);
    endtask

    task automatic test_full_backpressure();
        int c [6];
        int w [10];
        saw_full = 1'b0;
        prepare_op(issue_types_pkg::ALU_ADD, 0, 0, 1'b1, 12'h101, c[0]);
        for (int k = 1; k < 6; k++) begin
            prepare_op(issue_types_pkg::ALU_ADD, op_bundle[c[k - 1]].rd, 0, 1'b1,
                       IW'(k), c[k]);
        end
        for (int k = 0; k < 6; k += 2) dispatch_ops(c[k], c[k + 1], 1'b1);
        // the first four wait on the chain end, the rest are ready.
        for (int k = 0; k < 10; k++) begin
            prepare_op(issue_types_pkg::ALU_ADD, (k < 4) ? op_bundle[c[5]].rd : 0, 0, 1'b1,
                       IW'(16 + k), w[k]);
        end
        for (int k = 0; k < 10; k += 2) dispatch_ops(w[k], w[k + 1], 1'b1);
        if (!saw_full) stop_run("dis_full_o never rose while the queue was overfilled");
        for (int k = 0; k < 6; k++) check_op(c[k]);
        for (int k = 0; k < 10; k++) check_op(w[k]);
        for (int k = 0; k < 4; k++) check_before(c[5], w[k]);
    endtask

    initial begin
        void'($urandom(32'h3216af44));
        rst_n_i = 1'b0;
        dis_en_i = '0;
        dis_status_i = '0;
        dis_bundle_i = '0;
        for (int r = 0; r < 64; r++) begin
            model_regs[r] = '0;
            preg_written[r] = 1'b0;
        end
        for (int r = 0; r < 32; r++) got[r] = 1'b0;
        preg_written[0] = 1'b1;
        next_preg = 1;
        next_rob = 0;
        wb_count = 0;
        saw_full = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        test_independent_imm();
        test_every_opcode();
        test_dependency_chain();
        test_out_of_order();
        test_full_backpressure();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
